//--- hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // word and reset vector
    localparam int          XLEN     = 32;
    localparam logic [31:0] RESET_PC = 32'h1eceb000;

    // burst memory geometry
    localparam int BEAT_WIDTH       = 64;
    localparam int BEATS_PER_LINE   = 4;
    localparam int LINE_WIDTH       = BEAT_WIDTH * BEATS_PER_LINE;  // 256
    localparam int WORDS_PER_LINE   = LINE_WIDTH / XLEN;            // 8
    localparam int LINE_OFFSET_BITS = 5;                            // byte offset in a line

    // instruction queue
    localparam int IQ_DEPTH    = 16;
    localparam int IQ_PTR_BITS = 4;

    typedef logic [XLEN-1:0]       word_t;  // address or instruction
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [BEAT_WIDTH-1:0] beat_t;

    // one fetched instruction with its pc
    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_entry_t;

endpackage

`default_nettype wire

//--- hw/burst_line_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_line_adapter (
    input  wire logic             clk,
    input  wire logic             rst,

    // fill port towards the sequencer
    input  wire logic             fill_req_i,
    input  wire fetch_pkg::word_t fill_addr_i,
    output logic                  fill_busy_o,
    output logic                  fill_valid_o,
    output fetch_pkg::line_t      fill_line_o,
    output fetch_pkg::word_t      fill_line_addr_o,

    // burst memory
    output fetch_pkg::word_t      bmem_addr_o,
    output logic                  bmem_read_o,
    input  wire logic             bmem_ready_i,
    input  wire fetch_pkg::beat_t bmem_rdata_i,
    input  wire logic             bmem_rvalid_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,  // request taken, memory not ready yet
        ST_BEATS,       // read issued, collecting beats
        ST_DONE         // line complete
    } state_e;

    state_e                                        state_q, state_d;
    fetch_pkg::word_t                              req_addr;
    fetch_pkg::word_t                              addr_q;
    fetch_pkg::line_t                              line_q;
    logic [$clog2(fetch_pkg::BEATS_PER_LINE)-1:0]  beat_cnt_q;
    logic                                          last_beat;

    // drop the byte offset
    assign req_addr = {fill_addr_i[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFFSET_BITS],
                       {fetch_pkg::LINE_OFFSET_BITS{1'b0}}};

    assign last_beat = (beat_cnt_q == $bits(beat_cnt_q)'(fetch_pkg::BEATS_PER_LINE - 1));

    always_comb begin
        state_d     = state_q;
        bmem_read_o = 1'b0;
        bmem_addr_o = addr_q;
        case (state_q)
            ST_IDLE: begin
                bmem_addr_o = req_addr;  // pass through so the read can go out at once
                if (fill_req_i) begin
                    bmem_read_o = bmem_ready_i;
                    state_d     = bmem_ready_i ? ST_BEATS : ST_WAIT_READY;
                end
            end
            ST_WAIT_READY: begin
                bmem_read_o = bmem_ready_i;
                if (bmem_ready_i) begin
                    state_d = ST_BEATS;
                end
            end
            ST_BEATS: begin
                if (bmem_rvalid_i && last_beat) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            beat_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_BEATS && bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;  // wraps back to 0 after the last beat
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && fill_req_i) begin
            addr_q <= req_addr;
        end
        // beat 0 ends up in the low bits
        if (state_q == ST_BEATS && bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[fetch_pkg::LINE_WIDTH-1:fetch_pkg::BEAT_WIDTH]};
        end
    end

    assign fill_busy_o      = (state_q != ST_IDLE);
    assign fill_valid_o     = (state_q == ST_DONE);
    assign fill_line_o      = line_q;
    assign fill_line_addr_o = addr_q;

endmodule

`default_nettype wire

//--- hw/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer (
    input  wire logic             clk,
    input  wire logic             rst,

    // branch redirect
    input  wire logic             redirect_i,
    input  wire fetch_pkg::word_t redirect_pc_i,

    // line fill
    output logic                  fill_req_o,
    output fetch_pkg::word_t      fill_addr_o,
    input  wire logic             fill_busy_i,
    input  wire logic             fill_valid_i,
    input  wire fetch_pkg::line_t fill_line_i,
    input  wire fetch_pkg::word_t fill_line_addr_i,

    // instruction queue
    input  wire logic             queue_full_i,
    output logic                  push_o,
    output fetch_pkg::fetch_entry_t push_entry_o
);

    fetch_pkg::word_t pc_q, pc_d;

    // one-line buffer
    logic                                                  buf_valid_q;
    logic [fetch_pkg::XLEN-1:fetch_pkg::LINE_OFFSET_BITS]  buf_tag_q;
    fetch_pkg::line_t                                      buf_line_q;
    fetch_pkg::word_t                                      buf_words [fetch_pkg::WORDS_PER_LINE];

    logic             hit;
    fetch_pkg::word_t inst_word;
    fetch_pkg::word_t redirect_aligned;
    logic             fill_req_q;
    fetch_pkg::word_t fill_addr_q;

    // split the line into words, word 0 at the lowest address
    always_comb begin
        for (int w = 0; w < fetch_pkg::WORDS_PER_LINE; w++) begin
            buf_words[w] = buf_line_q[w*fetch_pkg::XLEN +: fetch_pkg::XLEN];
        end
    end

    assign hit = buf_valid_q &&
                 (buf_tag_q == pc_q[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFFSET_BITS]);

    assign inst_word = buf_words[pc_q[fetch_pkg::LINE_OFFSET_BITS-1:2]];

    assign redirect_aligned = {redirect_pc_i[fetch_pkg::XLEN-1:2], 2'b00};

    // one word per cycle while the line is present and the queue has room
    assign push_o            = hit && !queue_full_i && !redirect_i;
    assign push_entry_o.pc   = pc_q;
    assign push_entry_o.inst = inst_word;

    always_comb begin
        pc_d = pc_q;
        if (redirect_i) begin
            pc_d = redirect_aligned;
        end else if (push_o) begin
            pc_d = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q        <= fetch_pkg::RESET_PC;
            buf_valid_q <= 1'b0;
            fill_req_q  <= 1'b0;
        end else begin
            pc_q <= pc_d;
            // single-cycle request on a miss, never while a fill is pending
            fill_req_q <= !hit && !fill_busy_i && !fill_req_q && !redirect_i;
            if (fill_valid_i) begin
                buf_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        fill_addr_q <= pc_q;  // pc that missed
        // a late fill for an old pc still lands here
        if (fill_valid_i) begin
            buf_tag_q  <= fill_line_addr_i[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFFSET_BITS];
            buf_line_q <= fill_line_i;
        end
    end

    assign fill_req_o  = fill_req_q;
    assign fill_addr_o = fill_addr_q;

endmodule

`default_nettype wire

//--- hw/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    flush_i,

    // write side
    input  wire logic                    push_i,
    input  wire fetch_pkg::fetch_entry_t push_entry_i,
    output logic                         full_o,

    // decode side
    output fetch_pkg::word_t             inst_o,
    output fetch_pkg::word_t             inst_pc_o,
    output logic                         inst_valid_o,
    input  wire logic                    inst_ready_i
);

    fetch_pkg::fetch_entry_t                mem_q [fetch_pkg::IQ_DEPTH];
    logic [fetch_pkg::IQ_PTR_BITS-1:0]      wr_ptr_q, rd_ptr_q;
    logic [fetch_pkg::IQ_PTR_BITS:0]        count_q;
    logic                                   wr_en;
    logic                                   rd_en;

    assign inst_valid_o = (count_q != '0);
    assign full_o       = (count_q == (fetch_pkg::IQ_PTR_BITS+1)'(fetch_pkg::IQ_DEPTH));

    assign wr_en = push_i && !full_o && !flush_i;
    assign rd_en = inst_valid_o && inst_ready_i && !flush_i;

    // head entry
    assign inst_o    = mem_q[rd_ptr_q].inst;
    assign inst_pc_o = mem_q[rd_ptr_q].pc;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at IQ_DEPTH
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= push_entry_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input  wire logic             clk,
    input  wire logic             rst,

    // burst memory
    output fetch_pkg::word_t      bmem_addr_o,
    output logic                  bmem_read_o,
    input  wire logic             bmem_ready_i,
    input  wire fetch_pkg::beat_t bmem_rdata_i,
    input  wire logic             bmem_rvalid_i,

    // branch redirect
    input  wire logic             redirect_i,
    input  wire fetch_pkg::word_t redirect_pc_i,

    // decode
    output fetch_pkg::word_t      inst_o,
    output fetch_pkg::word_t      inst_pc_o,
    output logic                  inst_valid_o,
    input  wire logic             inst_ready_i
);

    // sequencer <-> adapter
    logic                    fill_req;
    fetch_pkg::word_t        fill_addr;
    logic                    fill_busy;
    logic                    fill_valid;
    fetch_pkg::line_t        fill_line;
    fetch_pkg::word_t        fill_line_addr;

    // sequencer <-> queue
    logic                    queue_full;
    logic                    push;
    fetch_pkg::fetch_entry_t push_entry;

    burst_line_adapter i_burst_line_adapter (
        .clk              (clk),
        .rst              (rst),
        .fill_req_i       (fill_req),
        .fill_addr_i      (fill_addr),
        .fill_busy_o      (fill_busy),
        .fill_valid_o     (fill_valid),
        .fill_line_o      (fill_line),
        .fill_line_addr_o (fill_line_addr),
        .bmem_addr_o      (bmem_addr_o),
        .bmem_read_o      (bmem_read_o),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_rvalid_i    (bmem_rvalid_i)
    );

    fetch_sequencer i_fetch_sequencer (
        .clk              (clk),
        .rst              (rst),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .fill_req_o       (fill_req),
        .fill_addr_o      (fill_addr),
        .fill_busy_i      (fill_busy),
        .fill_valid_i     (fill_valid),
        .fill_line_i      (fill_line),
        .fill_line_addr_i (fill_line_addr),
        .queue_full_i     (queue_full),
        .push_o           (push),
        .push_entry_o     (push_entry)
    );

    inst_queue i_inst_queue (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_i),  // redirect drops everything queued
        .push_i       (push),
        .push_entry_i (push_entry),
        .full_o       (queue_full),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .inst_valid_o (inst_valid_o),
        .inst_ready_i (inst_ready_i)
    );

endmodule

`default_nettype wire

//--- bench/bmem_model.sv
`timescale 1ns/1ps
`default_nettype none

module bmem_model (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             slow_i,  // long not-ready periods and wide beat gaps

    input  wire fetch_pkg::word_t bmem_addr_i,
    input  wire logic             bmem_read_i,
    output logic                  bmem_ready_o,
    output fetch_pkg::beat_t      bmem_rdata_o,
    output logic                  bmem_rvalid_o
);

    fetch_pkg::word_t req_addr   = '0;
    int unsigned      req_cnt    = 0;  // reads accepted
    int unsigned      served_cnt = 0;  // reads answered or in progress
    logic             busy       = 1'b0;
    fetch_pkg::word_t line_addr  = '0;
    int unsigned      beat       = 0;
    int unsigned      gap        = 0;
    int unsigned      ready_len  = 0;

    // every word holds its own address under a fixed mask
    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t addr);
        return addr ^ 32'h5a5a3c3c;
    endfunction

    function automatic int unsigned pick_gap();
        return slow_i ? $urandom % 8 : $urandom % 2;
    endfunction

    initial begin
        bmem_ready_o  = 1'b0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst && bmem_read_i && bmem_ready_o) begin
            req_addr = bmem_addr_i;
            req_cnt++;
        end
    end

    always @(negedge clk) begin
        bmem_rvalid_o = 1'b0;
        if (rst) begin
            bmem_ready_o = 1'b0;
            busy         = 1'b0;
            ready_len    = 0;
        end else begin
            // ready level comes in runs of random length
            if (ready_len == 0) begin
                bmem_ready_o = slow_i ? ($urandom % 2 == 0) : ($urandom % 4 != 0);
                if (bmem_ready_o) begin
                    ready_len = 1 + $urandom % (slow_i ? 6 : 10);
                end else begin
                    ready_len = slow_i ? 4 + $urandom % 24 : 1 + $urandom % 2;
                end
            end
            ready_len--;
            if (!busy && served_cnt != req_cnt) begin
                busy      = 1'b1;
                line_addr = req_addr;
                beat      = 0;
                gap       = pick_gap();
                served_cnt++;
            end
            if (busy) begin
                if (gap != 0) begin
                    gap--;
                end else begin
                    bmem_rvalid_o = 1'b1;
                    bmem_rdata_o  = {mem_word(line_addr + 32'(8 * beat + 4)),
                                     mem_word(line_addr + 32'(8 * beat))};  // little-endian beat
                    beat++;
                    gap = pick_gap();
                    if (beat == fetch_pkg::BEATS_PER_LINE) begin
                        busy = 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

    logic             clk;
    logic             rst;
    fetch_pkg::word_t bmem_addr;
    logic             bmem_read;
    logic             bmem_ready;
    fetch_pkg::beat_t bmem_rdata;
    logic             bmem_rvalid;
    logic             redirect;
    fetch_pkg::word_t redirect_pc;
    fetch_pkg::word_t inst;
    fetch_pkg::word_t inst_pc;
    logic             inst_valid;
    logic             inst_ready;
    logic             slow_mem;

    int unsigned      ready_mode  = 0;  // 0 low, 1 high, 2 random runs
    int unsigned      ready_len   = 0;
    fetch_pkg::word_t exp_pc      = fetch_pkg::RESET_PC;
    int unsigned      delivered   = 0;
    int unsigned      errors      = 0;
    int unsigned      tests_run   = 0;
    int unsigned      tests_clean = 0;
    logic             line_check  = 1'b1;  // reads must walk line by line
    fetch_pkg::word_t exp_line    = fetch_pkg::RESET_PC;
    logic             read_open   = 1'b0;
    int unsigned      beats_seen  = 0;
    logic             rst_q       = 1'b1;

    fetch_frontend i_fetch_frontend (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_o        (inst),
        .inst_pc_o     (inst_pc),
        .inst_valid_o  (inst_valid),
        .inst_ready_i  (inst_ready)
    );

    bmem_model i_bmem_model (
        .clk           (clk),
        .rst           (rst),
        .slow_i        (slow_mem),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic fetch_pkg::word_t ref_inst(input fetch_pkg::word_t pc);
        return pc ^ 32'h5a5a3c3c;
    endfunction

    function automatic fetch_pkg::word_t line_of(input fetch_pkg::word_t addr);
        return addr & ~((32'd1 << fetch_pkg::LINE_OFFSET_BITS) - 32'd1);
    endfunction

    // decode-side ready
    always @(negedge clk) begin
        if (rst || ready_mode == 0) begin
            inst_ready = 1'b0;
        end else if (ready_mode == 1) begin
            inst_ready = 1'b1;
        end else begin
            if (ready_len == 0) begin
                inst_ready = ($urandom % 3 == 0);
                ready_len  = inst_ready ? 1 + $urandom % 6 : 1 + $urandom % 40;
            end
            ready_len--;
        end
    end

    always @(posedge clk) begin
        if (rst || rst_q) begin
            if (inst_valid) begin
                $display("inst_valid_o is high during or right after reset");
                errors++;
            end
            if (bmem_read) begin
                $display("bmem_read_o is high during or right after reset");
                errors++;
            end
        end
        if (!rst) begin
            if (bmem_read) begin
                if (!bmem_ready) begin
                    $display("read pulse while bmem_ready_i is low");
                    errors++;
                end
                if (read_open) begin
                    $display("read pulse while the previous read is still open");
                    errors++;
                end
                if (bmem_addr != line_of(bmem_addr)) begin
                    $display("MISMATCH bmem_addr_o: got %h expected %h", bmem_addr,
                             line_of(bmem_addr));
                    errors++;
                end
                if (line_check && bmem_addr != exp_line) begin
                    $display("MISMATCH bmem_addr_o: got %h expected %h", bmem_addr, exp_line);
                    errors++;
                end
                exp_line   = exp_line + 32'd32;
                read_open  = 1'b1;
                beats_seen = 0;
            end
            if (bmem_rvalid) begin
                beats_seen++;
                if (beats_seen == fetch_pkg::BEATS_PER_LINE) begin
                    read_open = 1'b0;
                end
            end
            if (redirect) begin
                exp_pc     = {redirect_pc[31:2], 2'b00};
                line_check = 1'b0;  // an old fill may still be in flight
            end else if (inst_valid && inst_ready) begin
                if (inst_pc != exp_pc) begin
                    $display("MISMATCH inst_pc_o: got %h expected %h", inst_pc, exp_pc);
                    errors++;
                end
                if (inst != ref_inst(exp_pc)) begin
                    $display("MISMATCH inst_o: got %h expected %h", inst, ref_inst(exp_pc));
                    errors++;
                end
                exp_pc = exp_pc + 32'd4;  // next word in program order
                delivered++;
            end
        end
        rst_q = rst;
    end

    task automatic wait_entries(input int unsigned count, input int unsigned limit);
        int unsigned target;
        int unsigned cycles;
        target = delivered + count;
        cycles = 0;
        while (delivered < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (delivered < target) begin
            $display("timeout: %0d of %0d entries after %0d cycles",
                     count - (target - delivered), count, cycles);
            $display("test failed");
            $finish;
        end
    endtask

    task automatic apply_redirect(input fetch_pkg::word_t target);
        @(negedge clk);
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect    = 1'b0;
    endtask

    task automatic report_case(input string name, input int unsigned errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_clean++;
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int unsigned mark;
        void'($urandom(32'hb4f81318));
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        slow_mem    = 1'b0;
        inst_ready  = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        mark       = errors;
        ready_mode = 1;
        wait_entries(1, 400);
        report_case("reset", mark);

        mark = errors;
        wait_entries(40, 2000);
        report_case("sequential stream", mark);

        mark       = errors;
        ready_mode = 2;
        wait_entries(60, 8000);
        ready_mode = 1;
        report_case("back-pressure", mark);

        mark     = errors;
        slow_mem = 1'b1;
        wait_entries(40, 10000);
        slow_mem = 1'b0;
        report_case("slow memory", mark);

        mark       = errors;
        ready_mode = 2;
        repeat (5) begin
            apply_redirect($urandom & 32'hfffffffc);
            wait_entries(12, 4000);
        end
        report_case("redirect", mark);

        $display("summary: %0d cases, %0d clean, %0d check errors",
                 tests_run, tests_clean, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hw/fetch_pkg.sv
hw/burst_line_adapter.sv
hw/fetch_sequencer.sv
hw/inst_queue.sv
hw/fetch_frontend.sv
bench/bmem_model.sv
bench/tb_fetch_frontend.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/burst_line_adapter.sv
      - hw/fetch_sequencer.sv
      - hw/inst_queue.sv
      - hw/fetch_frontend.sv
  - target: test
    files:
      - bench/bmem_model.sv
      - bench/tb_fetch_frontend.sv
